// File: logic/movegen_config.svh
`ifndef MOVEGEN_CONFIG_SVH
`define MOVEGEN_CONFIG_SVH

// board geometry
`define MG_FILES 8

// 2 castling slots, then 14 en passant slots (two per file, one for a and h)
`define MG_SLOTS 16

// deep enough for a full candidate set, so the scan never stalls
`define MG_FIFO_DEPTH 16

// side codes, the top bit of a square
`define MG_WHITE 1'b0
`define MG_BLACK 1'b1

// piece codes, the low three bits of a square
`define MG_EMPTY 3'd0
`define MG_PAWN 3'd1
`define MG_ROOK 3'd4
`define MG_KING 3'd6

// flag words: invalid promote pawn pawn2 enp castle capture
`define MG_FLAGS_CASTLE 7'b0000010
`define MG_FLAGS_ENP 7'b0010101

`endif

// File: logic/movegen_pkg.sv
`include "movegen_config.svh"

package movegen_pkg;

	typedef logic [3:0] square_t; // color bit above piece code
	typedef logic [255:0] board_t; // square i in bits 4i+3:4i, i = rank*8 + file
	typedef logic [31:0] row_t; // one rank, file a in the low nibble
	typedef logic [5:0] sq_pos_t; // file above rank, e1 = 6'o40
	typedef logic [6:0] move_flags_t;
	typedef logic [7:0] file_mask_t; // bit 0 is file a

	typedef struct packed {
		move_flags_t flags;
		sq_pos_t from;
		sq_pos_t to;
	} move_t;

	typedef struct packed {
		logic castle_long; // a rook and king unmoved
		logic castle_short; // h rook and king unmoved
		file_mask_t enp_files; // black pawn just made a double step on that file
	} side_flags_s;

	// only the two ranks the special moves look at
	typedef struct packed {
		row_t rank1;
		row_t rank5;
	} board_rows_s;

	typedef struct packed {
		logic [`MG_SLOTS-1:0] valid;
		move_t [`MG_SLOTS-1:0] moves;
	} candidate_set_s;

	typedef enum logic [1:0] {
		q_idle,
		q_scan,
		q_done
	} queue_state_e;

endpackage

// File: logic/board_reader.sv
`timescale 1ns/10ps
`include "movegen_config.svh"

module board_reader
	import movegen_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic ready,
	input board_t board,
	input side_flags_s side_flags_in,
	output board_rows_s rows,
	output side_flags_s flags,
	output logic board_valid
);

	localparam int SQ_W = $bits(square_t);
	localparam int ROW_W = `MG_FILES * SQ_W;
	localparam int RANK1 = 0;
	localparam int RANK5 = 4;

	logic accept;
	row_t rank1_in;
	row_t rank5_in;

	// a start is only taken while the queue can accept a new run
	assign accept = start && ready;

	assign rank1_in = board[RANK1 * ROW_W +: ROW_W];
	assign rank5_in = board[RANK5 * ROW_W +: ROW_W];

	always_ff @(posedge clk) begin
		if (reset) begin
			board_valid <= 1'b0;
		end else begin
			board_valid <= accept; // one cycle pulse per accepted run
		end
	end

	// the other six ranks play no part in castling or en passant
	always_ff @(posedge clk) begin
		if (accept) begin
			rows.rank1 <= rank1_in;
			rows.rank5 <= rank5_in;
			flags <= side_flags_in;
		end
	end

endmodule

// File: logic/special_move_gen.sv
`timescale 1ns/10ps
`include "movegen_config.svh"

module special_move_gen
	import movegen_pkg::*;
(
	input logic clk,
	input logic reset,
	input board_rows_s rows,
	input side_flags_s flags,
	input logic board_valid,
	output candidate_set_s cands,
	output logic cands_valid
);

	localparam int SQ_W = $bits(square_t);
	localparam int ENP_FIRST = 2; // first en passant slot

	localparam square_t W_KING = {`MG_WHITE, `MG_KING};
	localparam square_t W_ROOK = {`MG_WHITE, `MG_ROOK};
	localparam square_t W_PAWN = {`MG_WHITE, `MG_PAWN};

	localparam sq_pos_t SQ_E1 = 6'o40;
	localparam sq_pos_t SQ_G1 = 6'o60;
	localparam sq_pos_t SQ_C1 = 6'o20;
	localparam logic [2:0] RANK5 = 3'd4;
	localparam logic [2:0] RANK6 = 3'd5;

	candidate_set_s next_cands;
	logic castle_short_ok;
	logic castle_long_ok;

	function automatic square_t square_at(input row_t row, input int file);
		return row[file * SQ_W +: SQ_W];
	endfunction

	// emptiness looks at the piece code only
	function automatic logic is_empty(input square_t sq);
		return sq[2:0] == `MG_EMPTY;
	endfunction

	// king checks (in check, passing through attack) are left to the caller
	assign castle_short_ok = flags.castle_short
		&& square_at(rows.rank1, 4) == W_KING
		&& is_empty(square_at(rows.rank1, 5))
		&& is_empty(square_at(rows.rank1, 6))
		&& square_at(rows.rank1, 7) == W_ROOK;

	assign castle_long_ok = flags.castle_long
		&& square_at(rows.rank1, 4) == W_KING
		&& is_empty(square_at(rows.rank1, 3))
		&& is_empty(square_at(rows.rank1, 2))
		&& is_empty(square_at(rows.rank1, 1))
		&& square_at(rows.rank1, 0) == W_ROOK;

	// en passant slots run a-right, b-left, b-right ... g-right, h-left
	// so for target file t the left neighbor sits in 2t+1, the right one in 2t+2
	always_comb begin
		int tgt;
		int nbr;

		next_cands = '0;

		next_cands.valid[0] = castle_short_ok;
		next_cands.moves[0] = '{flags: `MG_FLAGS_CASTLE, from: SQ_E1, to: SQ_G1};
		next_cands.valid[1] = castle_long_ok;
		next_cands.moves[1] = '{flags: `MG_FLAGS_CASTLE, from: SQ_E1, to: SQ_C1};

		for (int s = ENP_FIRST; s < `MG_SLOTS; s++) begin
			tgt = (s - 1) / 2;
			nbr = (s % 2 == 1) ? tgt - 1 : tgt + 1;
			if (flags.enp_files[tgt] && square_at(rows.rank5, nbr) == W_PAWN) begin
				next_cands.valid[s] = 1'b1;
				next_cands.moves[s] = '{
					flags: `MG_FLAGS_ENP,
					from: {3'(nbr), RANK5},
					to: {3'(tgt), RANK6}
				};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cands_valid <= 1'b0;
		end else begin
			cands_valid <= board_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (board_valid) begin
			cands <= next_cands;
		end
	end

endmodule

// File: logic/move_queue.sv
`timescale 1ns/10ps
`include "movegen_config.svh"

module move_queue
	import movegen_pkg::*;
(
	input logic clk,
	input logic reset,
	input candidate_set_s cands,
	input logic cands_valid,
	input logic rden,
	output logic ready,
	output logic done,
	output logic empty,
	output move_t move_out
);

	localparam int SLOT_W = $clog2(`MG_SLOTS);
	localparam int PTR_W = $clog2(`MG_FIFO_DEPTH);

	queue_state_e state;
	logic [SLOT_W-1:0] slot;

	move_t fifo_mem [0:`MG_FIFO_DEPTH-1];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;

	logic scanning;
	logic wr_en;
	logic rd_en;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(`MG_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// slot 0 is taken on the cands_valid edge itself, slots 1..15 in q_scan
	// the counter wraps back to 0 after slot 15, which ends the scan
	assign scanning = (state == q_scan) ? (slot != '0) : cands_valid;
	assign wr_en = scanning && cands.valid[slot];
	assign rd_en = rden && !empty; // pop on empty is dropped

	assign empty = (count == '0);
	assign move_out = fifo_mem[rd_ptr]; // show-ahead
	assign done = (state == q_done);
	assign ready = (state != q_scan) && empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= q_idle;
			slot <= '0;
		end else begin
			case (state)
				q_idle, q_done: begin
					if (cands_valid) begin
						state <= q_scan;
						slot <= slot + 1'b1;
					end
				end
				q_scan: begin
					if (slot == '0) begin
						state <= q_done;
					end else begin
						slot <= slot + 1'b1;
					end
				end
				default: begin
					state <= q_idle;
					slot <= '0;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			fifo_mem[wr_ptr] <= cands.moves[slot];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (rd_en) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: logic/move_gen_top.sv
`timescale 1ns/10ps

module move_gen_top
	import movegen_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input board_t board,
	input side_flags_s side_flags,
	input logic rden,
	output logic done,
	output logic empty,
	output move_t move_out
);

	logic ready;
	board_rows_s rows;
	side_flags_s flags;
	logic board_valid;
	candidate_set_s cands;
	logic cands_valid;

	board_reader u_board_reader (
		.clk(clk),
		.reset(reset),
		.start(start),
		.ready(ready),
		.board(board),
		.side_flags_in(side_flags),
		.rows(rows),
		.flags(flags),
		.board_valid(board_valid)
	);

	special_move_gen u_special_move_gen (
		.clk(clk),
		.reset(reset),
		.rows(rows),
		.flags(flags),
		.board_valid(board_valid),
		.cands(cands),
		.cands_valid(cands_valid)
	);

	move_queue u_move_queue (
		.clk(clk),
		.reset(reset),
		.cands(cands),
		.cands_valid(cands_valid),
		.rden(rden),
		.ready(ready),
		.done(done),
		.empty(empty),
		.move_out(move_out)
	);

endmodule

// File: bench/move_gen_model.svh
`ifndef MOVE_GEN_MODEL_SVH
`define MOVE_GEN_MODEL_SVH

// expected special moves in the order they leave the FIFO
// castling first (short then long), then en passant by target file, left pawn before right

function automatic square_t piece_at(input board_t b, input int file, input int rank);
	return b[(rank * 8 + file) * 4 +: 4];
endfunction

function automatic sq_pos_t square_pos(input int file, input int rank);
	return {3'(file), 3'(rank)};
endfunction

function automatic logic vacant(input square_t sq);
	return sq[2:0] == `MG_EMPTY; // color bit does not matter
endfunction

function automatic move_t make_move(input move_flags_t fl, input sq_pos_t from, input sq_pos_t to);
	move_t m;
	m.flags = fl;
	m.from = from;
	m.to = to;
	return m;
endfunction

function automatic void build_expected(input board_t b, input side_flags_s f);
	square_t w_king;
	square_t w_rook;
	square_t w_pawn;
	w_king = {`MG_WHITE, `MG_KING};
	w_rook = {`MG_WHITE, `MG_ROOK};
	w_pawn = {`MG_WHITE, `MG_PAWN};
	exp_moves.delete();
	if (f.castle_short && piece_at(b, 4, 0) == w_king && vacant(piece_at(b, 5, 0))
		&& vacant(piece_at(b, 6, 0)) && piece_at(b, 7, 0) == w_rook) begin
		exp_moves.push_back(make_move(`MG_FLAGS_CASTLE, square_pos(4, 0), square_pos(6, 0)));
	end
	if (f.castle_long && piece_at(b, 4, 0) == w_king && vacant(piece_at(b, 3, 0))
		&& vacant(piece_at(b, 2, 0)) && vacant(piece_at(b, 1, 0))
		&& piece_at(b, 0, 0) == w_rook) begin
		exp_moves.push_back(make_move(`MG_FLAGS_CASTLE, square_pos(4, 0), square_pos(2, 0)));
	end
	// pawn on rank 5 next to the flagged file lands on rank 6 of that file
	for (int t = 0; t < `MG_FILES; t++) begin
		if (f.enp_files[t]) begin
			if (t > 0 && piece_at(b, t - 1, 4) == w_pawn) begin
				exp_moves.push_back(make_move(`MG_FLAGS_ENP, square_pos(t - 1, 4),
					square_pos(t, 5)));
			end
			if (t < `MG_FILES - 1 && piece_at(b, t + 1, 4) == w_pawn) begin
				exp_moves.push_back(make_move(`MG_FLAGS_ENP, square_pos(t + 1, 4),
					square_pos(t, 5)));
			end
		end
	end
endfunction

`endif

// File: bench/move_gen_tb.sv
`timescale 1ns/10ps
`include "movegen_config.svh"

module move_gen_tb
	import movegen_pkg::*;
();

	logic clk;
	logic reset;
	logic start;
	board_t board;
	side_flags_s side_flags;
	logic rden;
	logic done;
	logic empty;
	move_t move_out;

	integer seed;
	move_t exp_moves[$];
	move_t got_moves[$];

	localparam square_t W_PAWN = {`MG_WHITE, `MG_PAWN};
	localparam square_t B_PAWN = {`MG_BLACK, `MG_PAWN};
	localparam square_t W_ROOK = {`MG_WHITE, `MG_ROOK};
	localparam square_t B_ROOK = {`MG_BLACK, `MG_ROOK};
	localparam square_t W_KING = {`MG_WHITE, `MG_KING};

	`include "move_gen_model.svh"

	move_gen_top u_dut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.board(board),
		.side_flags(side_flags),
		.rden(rden),
		.done(done),
		.empty(empty),
		.move_out(move_out)
	);

	always #4 clk = ~clk;

	task automatic stop_run();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	// the FIFO head only ever holds castling or en passant words
	head_flags_known: assert property (@(posedge clk) disable iff (reset)
		!empty |-> (move_out.flags == `MG_FLAGS_CASTLE || move_out.flags == `MG_FLAGS_ENP))
		else begin
			$display("FIFO head shows a move with an unknown flag word");
			stop_run();
		end

	task automatic check_equal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (expected == actual) else begin
			$display("** Error %s: expected %0h, actual %0h", name, expected, actual);
			stop_run();
		end
	endtask

	function automatic board_t place(input board_t b, input int file, input int rank,
		input square_t sq);
		board_t r;
		r = b;
		r[(rank * 8 + file) * 4 +: 4] = sq;
		return r;
	endfunction

	function automatic board_t castle_board();
		board_t b;
		b = '0;
		b = place(b, 0, 0, W_ROOK);
		b = place(b, 4, 0, W_KING);
		b = place(b, 7, 0, W_ROOK);
		return b;
	endfunction

	function automatic side_flags_s make_flags(input logic lng, input logic sht,
		input file_mask_t enp);
		side_flags_s f;
		f.castle_long = lng;
		f.castle_short = sht;
		f.enp_files = enp;
		return f;
	endfunction

	function automatic square_t random_square();
		logic [31:0] r;
		r = $random(seed);
		case (r[5:4])
			2'd0: return 4'h0;
			2'd1: return W_PAWN;
			2'd2: return B_PAWN;
			default: return r[3:0];
		endcase
	endfunction

	// pulse start and wait for done, which must rise 18 edges after the accepting one
	task automatic start_run(input string name, input board_t b, input side_flags_s f);
		int cycles;
		build_expected(b, f);
		@(posedge clk);
		#1;
		start = 1'b1;
		board = b;
		side_flags = f;
		@(posedge clk);
		#1;
		start = 1'b0;
		cycles = 0;
		while (cycles < 40) begin
			@(negedge clk);
			if (cycles >= 2 && done) break;
			@(posedge clk);
			cycles++;
		end
		if (!done) begin
			$display("timeout: done never rose in %s", name);
			stop_run();
		end
		check_equal({name, " done latency"}, 18, cycles);
		if (exp_moves.size() > 0) check_equal({name, " empty at done"}, 0, 32'(empty));
	endtask

	task automatic drain_and_compare(input string name);
		int guard;
		got_moves.delete();
		@(posedge clk);
		#1;
		rden = 1'b1; // held high, the pop lands on the edge after each sample
		guard = 0;
		while (guard <= `MG_FIFO_DEPTH) begin
			@(negedge clk);
			if (empty) break;
			got_moves.push_back(move_out);
			guard++;
		end
		@(posedge clk);
		#1;
		rden = 1'b0;
		if (!empty) begin
			$display("FIFO still holds moves after %0d reads in %s", guard, name);
			stop_run();
		end
		check_equal({name, " count"}, exp_moves.size(), got_moves.size());
		for (int i = 0; i < got_moves.size(); i++) begin
			check_equal($sformatf("%s move %0d", name, i), 32'(exp_moves[i]),
				32'(got_moves[i]));
		end
	endtask

	task automatic run_counted(input string name, input board_t b, input side_flags_s f,
		input int n_exp);
		start_run(name, b, f);
		drain_and_compare(name);
		check_equal({name, " length"}, n_exp, got_moves.size());
	endtask

	task automatic random_runs(input int n);
		board_t b;
		board_t base;
		side_flags_s f;
		logic [31:0] r;
		base = castle_board();
		for (int i = 0; i < n; i++) begin
			for (int w = 0; w < 8; w++) b[w * 32 +: 32] = $random(seed);
			b[31:0] = base[31:0]; // start rank 1 from the castling layout
			for (int file = 0; file < `MG_FILES; file++) begin
				r = $random(seed);
				if (r[1:0] == 2'd0) b = place(b, file, 0, random_square());
				b = place(b, file, 4, random_square());
			end
			r = $random(seed);
			f = make_flags(r[8], r[9], r[7:0]);
			start_run($sformatf("random %0d", i), b, f);
			drain_and_compare($sformatf("random %0d", i));
		end
	endtask

	initial begin
		board_t b;
		seed = 21946;
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		board = '0;
		side_flags = '0;
		rden = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		// idle outputs, pops on an empty FIFO are dropped
		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			#1;
			rden = 1'b1;
			@(negedge clk);
			check_equal("reset done", 0, 32'(done));
			check_equal("reset empty", 1, 32'(empty));
		end
		@(posedge clk);
		#1;
		rden = 1'b0;

		run_counted("castle both", castle_board(), make_flags(1'b1, 1'b1, 8'h00), 2);
		check_equal("castle both first", 32'(make_move(`MG_FLAGS_CASTLE, 6'o40, 6'o60)),
			32'(got_moves[0]));
		check_equal("castle both second", 32'(make_move(`MG_FLAGS_CASTLE, 6'o40, 6'o20)),
			32'(got_moves[1]));
		run_counted("castle f1 blocked", place(castle_board(), 5, 0, B_ROOK),
			make_flags(1'b1, 1'b1, 8'h00), 1);
		run_counted("castle b1 blocked", place(castle_board(), 1, 0, B_PAWN),
			make_flags(1'b1, 1'b1, 8'h00), 1);
		run_counted("castle c1 blocked", place(castle_board(), 2, 0, W_PAWN),
			make_flags(1'b1, 1'b1, 8'h00), 1);
		run_counted("castle no h rook", place(castle_board(), 7, 0, 4'h0),
			make_flags(1'b1, 1'b1, 8'h00), 1);
		run_counted("castle black a rook", place(castle_board(), 0, 0, B_ROOK),
			make_flags(1'b1, 1'b1, 8'h00), 1);
		run_counted("castle no king", place(castle_board(), 4, 0, 4'h0),
			make_flags(1'b1, 1'b1, 8'h00), 0);
		run_counted("castle short off", castle_board(), make_flags(1'b1, 1'b0, 8'h00), 1);
		run_counted("castle long off", castle_board(), make_flags(1'b0, 1'b1, 8'h00), 1);

		b = place(place('0, 2, 4, W_PAWN), 4, 4, W_PAWN);
		run_counted("enp d", b, make_flags(1'b0, 1'b0, 8'h08), 2);
		check_equal("enp d first", 32'(make_move(`MG_FLAGS_ENP, 6'o24, 6'o35)),
			32'(got_moves[0]));
		check_equal("enp d second", 32'(make_move(`MG_FLAGS_ENP, 6'o44, 6'o35)),
			32'(got_moves[1]));
		run_counted("enp a", place('0, 1, 4, W_PAWN), make_flags(1'b0, 1'b0, 8'h01), 1);
		check_equal("enp a move", 32'(make_move(`MG_FLAGS_ENP, 6'o14, 6'o05)),
			32'(got_moves[0]));
		run_counted("enp h", place('0, 6, 4, W_PAWN), make_flags(1'b0, 1'b0, 8'h80), 1);
		check_equal("enp h move", 32'(make_move(`MG_FLAGS_ENP, 6'o64, 6'o75)),
			32'(got_moves[0]));
		// one pawn on d5 serves both flagged neighbors
		run_counted("enp c and e", place('0, 3, 4, W_PAWN), make_flags(1'b0, 1'b0, 8'h14), 2);
		b = place(place('0, 2, 4, B_PAWN), 4, 4, B_PAWN);
		run_counted("enp black", b, make_flags(1'b0, 1'b0, 8'h08), 0);
		run_counted("enp empty", '0, make_flags(1'b0, 1'b0, 8'h08), 0);

		b = castle_board();
		for (int file = 0; file < `MG_FILES; file++) b = place(b, file, 4, W_PAWN);
		run_counted("all sixteen", b, make_flags(1'b1, 1'b1, 8'hff), 16);

		random_runs(200);

		// a start is ignored while moves wait in the FIFO
		b = place(place('0, 2, 4, W_PAWN), 4, 4, W_PAWN);
		start_run("busy", b, make_flags(1'b1, 1'b0, 8'h08));
		@(posedge clk);
		#1;
		start = 1'b1;
		board = castle_board();
		side_flags = make_flags(1'b1, 1'b1, 8'h00);
		@(posedge clk);
		#1;
		start = 1'b0;
		for (int i = 0; i < 24; i++) begin
			@(negedge clk);
			check_equal("busy done", 1, 32'(done));
			check_equal("busy empty", 0, 32'(empty));
		end
		drain_and_compare("busy");
		run_counted("after drain", castle_board(), make_flags(1'b1, 1'b1, 8'h00), 2);

		$display("TEST OK");
		$finish;
	end

endmodule

// File: sources.f
+incdir+logic
+incdir+bench
logic/movegen_pkg.sv
logic/board_reader.sv
logic/special_move_gen.sv
logic/move_queue.sv
logic/move_gen_top.sv
bench/move_gen_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module move_gen_tb -f sources.f -o move_gen_sim

# the simulator exits nonzero on a fatal check, the log decides the result
./obj_dir/move_gen_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
grep -q "TEST OK" sim.log
